//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_stream_dma
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
verilog/stream_dma_pkg.sv
verilog/block_fetch.sv
verilog/block_store.sv
verilog/host_read_gate.sv
verilog/stream_dma_top.sv
verif/tb_mem_model.sv
verif/tb_stream_dma.sv

//--- verif/tb_mem_model.sv
// --------------------
// burst memory model
// accepts one write and one read burst at a time, answers B with okay,
// outputs change on the falling clock edge
// --------------------

`timescale 1ns/1ns

module tb_mem_model (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  stream_dma_pkg::addr_req_t aw,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  stream_dma_pkg::wbeat_t    w,
  input  logic                      w_valid,
  output logic                      w_ready,
  output stream_dma_pkg::resp_e     b_resp,
  output logic                      b_valid,
  input  logic                      b_ready,
  input  stream_dma_pkg::addr_req_t ar,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  output stream_dma_pkg::rbeat_t    r,
  output logic                      r_valid,
  input  logic                      r_ready
);

  localparam int idx_w = stream_dma_pkg::addr_w - 3;

  stream_dma_pkg::data_t                mem [0:(2**idx_w)-1];
  logic [idx_w-1:0]                     wr_idx;
  logic [idx_w-1:0]                     rd_idx;
  logic [stream_dma_pkg::len_w-1:0]     rd_left;
  logic                                 wr_active;
  logic                                 b_pending;
  logic                                 rd_active;

  // transfers are taken on the rising edge
  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_idx    <= '0;
      rd_idx    <= '0;
      rd_left   <= '0;
      wr_active <= 1'b0;
      b_pending <= 1'b0;
      rd_active <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) begin
        wr_active <= 1'b1;
        wr_idx    <= aw.addr[stream_dma_pkg::addr_w-1:3];
      end
      if (w_valid && w_ready) begin
        mem[wr_idx] <= w.data;
        wr_idx      <= wr_idx + 1'b1;
        if (w.last) begin
          wr_active <= 1'b0;
          b_pending <= 1'b1;
        end
      end
      if (b_valid && b_ready) begin
        b_pending <= 1'b0;
      end
      if (ar_valid && ar_ready) begin
        rd_active <= 1'b1;
        rd_idx    <= ar.addr[stream_dma_pkg::addr_w-1:3];
        rd_left   <= ar.len;
      end
      if (r_valid && r_ready) begin
        if (rd_left == '0) begin
          rd_active <= 1'b0;
        end else begin
          rd_idx  <= rd_idx + 1'b1;
          rd_left <= rd_left - 1'b1;
        end
      end
    end
  end

  // --------------------
  // output drive
  // --------------------
  initial begin
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    b_resp   = stream_dma_pkg::okay;
    b_valid  = 1'b0;
    ar_ready = 1'b0;
    r        = '0;
    r_valid  = 1'b0;
    forever begin
      @(negedge aclk);
      aw_ready = !wr_active && !b_pending;
      w_ready  = wr_active;
      b_valid  = b_pending;
      ar_ready = !rd_active;
      r_valid  = rd_active;
      r.data   = mem[rd_idx];
      r.last   = (rd_left == '0);
      r.resp   = stream_dma_pkg::okay;
    end
  end

endmodule

//--- verif/tb_stream_dma.sv
// --------------------
// stream dma testbench
// host writes table blocks, an inverting kernel loops fifo_in to fifo_out,
// host reads the results back from memory C
// --------------------

`timescale 1ns/1ns

module tb_stream_dma;

  localparam int n_blocks  = 3;
  localparam int bpb       = stream_dma_pkg::beats_per_block;
  localparam int cyc_limit = 400 * n_blocks + 200;

  // stimulus table, one entry per block
  localparam logic [31:0] seed_tab  [0:n_blocks-1] = '{32'h1234abcd, 32'h0f0f5a5a, 32'hdeadc0de};
  localparam logic [15:0] stall_tab [0:n_blocks-1] = '{16'hffff, 16'ha5a5, 16'h3c0f};

  logic aclk;
  logic aresetn;
  stream_dma_pkg::addr_req_t host_aw, host_ar, ddra_aw, ddra_ar, ddrc_aw, ddrc_ar;
  stream_dma_pkg::wbeat_t    host_w, ddra_w, ddrc_w;
  stream_dma_pkg::rbeat_t    host_r, ddra_r, ddrc_r;
  stream_dma_pkg::resp_e     host_b_resp, ddra_b_resp, ddrc_b_resp;
  logic host_aw_valid, host_aw_ready, host_w_valid, host_w_ready, host_b_valid, host_b_ready;
  logic host_ar_valid, host_ar_ready, host_r_valid, host_r_ready;
  logic ddra_aw_valid, ddra_aw_ready, ddra_w_valid, ddra_w_ready, ddra_b_valid, ddra_b_ready;
  logic ddra_ar_valid, ddra_ar_ready, ddra_r_valid, ddra_r_ready;
  logic ddrc_aw_valid, ddrc_aw_ready, ddrc_w_valid, ddrc_w_ready, ddrc_b_valid, ddrc_b_ready;
  logic ddrc_ar_valid, ddrc_ar_ready, ddrc_r_valid, ddrc_r_ready;
  stream_dma_pkg::data_t fifo_in_bits, fifo_out_bits;
  logic fifo_in_vld, fifo_in_rdy, fifo_out_vld, fifo_out_rdy;

  stream_dma_pkg::data_t exp_data [0:n_blocks*bpb-1];
  stream_dma_pkg::data_t kernel_q [$];
  logic [31:0] lfsr_state;
  bit kernel_en;
  int cycles, err_cnt, writes_done;
  int ar_cnt, in_cnt, aw_cnt, w_cnt, r_cnt;

  stream_dma_top i_stream_dma_top (.*);

  tb_mem_model i_mem_a (
    .aclk (aclk), .aresetn (aresetn),
    .aw (ddra_aw), .aw_valid (ddra_aw_valid), .aw_ready (ddra_aw_ready),
    .w (ddra_w), .w_valid (ddra_w_valid), .w_ready (ddra_w_ready),
    .b_resp (ddra_b_resp), .b_valid (ddra_b_valid), .b_ready (ddra_b_ready),
    .ar (ddra_ar), .ar_valid (ddra_ar_valid), .ar_ready (ddra_ar_ready),
    .r (ddra_r), .r_valid (ddra_r_valid), .r_ready (ddra_r_ready)
  );

  tb_mem_model i_mem_c (
    .aclk (aclk), .aresetn (aresetn),
    .aw (ddrc_aw), .aw_valid (ddrc_aw_valid), .aw_ready (ddrc_aw_ready),
    .w (ddrc_w), .w_valid (ddrc_w_valid), .w_ready (ddrc_w_ready),
    .b_resp (ddrc_b_resp), .b_valid (ddrc_b_valid), .b_ready (ddrc_b_ready),
    .ar (ddrc_ar), .ar_valid (ddrc_ar_valid), .ar_ready (ddrc_ar_ready),
    .r (ddrc_r), .r_valid (ddrc_r_valid), .r_ready (ddrc_r_ready)
  );

  task automatic check_equal(input logic [63:0] got, input logic [63:0] expected,
                             input string what);
    if (got !== expected) begin
      err_cnt++;
      $display("ERROR @ %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic build_block_data();
    logic [63:0] word;
    lfsr_state = 32'd81844;
    for (int n = 0; n < n_blocks * bpb; n++) begin
      word = '0;
      for (int b = 0; b < 64; b++) begin
        word       = {word[62:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
      end
      exp_data[n] = word ^ {seed_tab[n / bpb], seed_tab[n / bpb]};
    end
  endtask

  function automatic stream_dma_pkg::addr_t block_addr(input int k);
    return stream_dma_pkg::addr_t'(k) * stream_dma_pkg::block_bytes;
  endfunction

  function automatic int kernel_block();
    int b;
    b = in_cnt / bpb;
    return (b < n_blocks) ? b : n_blocks - 1;
  endfunction

  task automatic write_block(input int k);
    @(negedge aclk);
    host_aw.addr  = block_addr(k);
    host_aw.len   = stream_dma_pkg::burst_len;
    host_aw_valid = 1'b1;
    do @(posedge aclk); while (!host_aw_ready);
    @(negedge aclk);
    host_aw_valid = 1'b0;
    for (int i = 0; i < bpb; i++) begin
      host_w.data  = exp_data[k * bpb + i];
      host_w.last  = (i == bpb - 1);
      host_w_valid = 1'b1;
      do @(posedge aclk); while (!host_w_ready);
      @(negedge aclk);
    end
    host_w_valid = 1'b0;
    do @(posedge aclk); while (!host_b_valid);
    check_equal(64'(host_b_resp), 64'(stream_dma_pkg::okay), "host write response");
    writes_done <= writes_done + 1;
  endtask

  task automatic read_block(input int k, input bit gated);
    @(negedge aclk);
    host_ar.addr  = block_addr(k);
    host_ar.len   = stream_dma_pkg::burst_len;
    host_ar_valid = 1'b1;
    if (gated) begin
      repeat (50) begin
        @(posedge aclk);
        check_equal(64'(host_ar_ready), 64'(0), "host_ar_ready before any stored block");
      end
      check_equal(64'(writes_done != 0), 64'(1), "host write during gated read");
      kernel_en = 1'b1;
    end
    do @(posedge aclk); while (!host_ar_ready);
    @(negedge aclk);
    host_ar_valid = 1'b0;
    while (r_cnt < (k + 1) * bpb) @(posedge aclk);
  endtask

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= cyc_limit) begin
      $display("timeout after %0d cycles, the transfers did not complete", cycles);
      $display("Something failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // monitors
  // --------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      if (ddra_ar_valid && ddra_ar_ready) begin
        check_equal(64'(ddra_ar.addr), 64'(block_addr(ar_cnt)), "ddra_ar addr");
        check_equal(64'(ddra_ar.len), 64'(stream_dma_pkg::burst_len), "ddra_ar len");
        ar_cnt <= ar_cnt + 1;
      end
      if (fifo_in_vld && fifo_in_rdy) begin
        check_equal(fifo_in_bits, exp_data[in_cnt], "fifo_in beat");
        kernel_q.push_back(~fifo_in_bits);
        in_cnt <= in_cnt + 1;
      end
      if (fifo_out_vld && fifo_out_rdy) begin
        void'(kernel_q.pop_front());
      end
      if (ddrc_aw_valid && ddrc_aw_ready) begin
        check_equal(64'(ddrc_aw.addr), 64'(block_addr(aw_cnt)), "ddrc_aw addr");
        check_equal(64'(ddrc_aw.len), 64'(stream_dma_pkg::burst_len), "ddrc_aw len");
        aw_cnt <= aw_cnt + 1;
      end
      if (ddrc_w_valid && ddrc_w_ready) begin
        check_equal(ddrc_w.data, ~exp_data[w_cnt], "ddrc_w data");
        check_equal(64'(ddrc_w.last), 64'(w_cnt % bpb == bpb - 1), "ddrc_w last");
        w_cnt <= w_cnt + 1;
      end
      if (host_r_valid && host_r_ready) begin
        check_equal(host_r.data, ~exp_data[r_cnt], "host_r data");
        check_equal(64'(host_r.last), 64'(r_cnt % bpb == bpb - 1), "host_r last");
        check_equal(64'(host_r.resp), 64'(stream_dma_pkg::okay), "host_r resp");
        r_cnt <= r_cnt + 1;
      end
    end
  end

  // inverting kernel, input stalls follow the block's pattern
  initial begin
    fifo_in_rdy   = 1'b0;
    fifo_out_vld  = 1'b0;
    fifo_out_bits = '0;
    forever begin
      @(negedge aclk);
      fifo_in_rdy  = kernel_en && stall_tab[kernel_block()][cycles[3:0]] && (kernel_q.size() < 4);
      fifo_out_vld = (kernel_q.size() != 0);
      if (kernel_q.size() != 0) begin
        fifo_out_bits = kernel_q[0];
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    aresetn       = 1'b0;
    host_aw       = '0;
    host_aw_valid = 1'b0;
    host_w        = '0;
    host_w_valid  = 1'b0;
    host_b_ready  = 1'b1;
    host_ar       = '0;
    host_ar_valid = 1'b0;
    host_r_ready  = 1'b1;
    kernel_en     = 1'b0;
    build_block_data();
    repeat (4) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    @(posedge aclk);
    check_equal(64'(ddra_ar_valid), 64'(0), "ddra_ar_valid after reset");
    check_equal(64'(ddrc_aw_valid), 64'(0), "ddrc_aw_valid after reset");
    check_equal(64'(ddrc_ar_valid), 64'(0), "ddrc_ar_valid after reset");
    check_equal(64'(host_ar_ready), 64'(0), "host_ar_ready after reset");
    fork
      begin
        for (int k = 0; k < n_blocks; k++) write_block(k);
      end
      begin
        for (int k = 0; k < n_blocks; k++) read_block(k, k == 0);
      end
    join
    // every credit used, a further read must wait
    @(negedge aclk);
    host_ar.addr  = block_addr(n_blocks);
    host_ar_valid = 1'b1;
    repeat (50) begin
      @(posedge aclk);
      check_equal(64'(host_ar_ready), 64'(0), "host_ar_ready with no credit left");
    end
    @(negedge aclk);
    host_ar_valid = 1'b0;
    check_equal(64'(ar_cnt), 64'(n_blocks), "ddra_ar burst count");
    check_equal(64'(in_cnt), 64'(n_blocks * bpb), "fifo_in beat count");
    check_equal(64'(aw_cnt), 64'(n_blocks), "ddrc_aw burst count");
    check_equal(64'(w_cnt), 64'(n_blocks * bpb), "ddrc_w beat count");
    check_equal(64'(r_cnt), 64'(n_blocks * bpb), "host_r beat count");
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- verilog/block_fetch.sv
// --------------------
// block fetcher
// counts host block writes to memory A, reads each block back in order
// and streams its beats to the kernel input
// --------------------

`timescale 1ns/1ns

module block_fetch (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      ddra_b_valid,
  input  logic                      host_b_ready,
  output stream_dma_pkg::addr_req_t ddra_ar,
  output logic                      ddra_ar_valid,
  input  logic                      ddra_ar_ready,
  input  stream_dma_pkg::rbeat_t    ddra_r,
  input  logic                      ddra_r_valid,
  output logic                      ddra_r_ready,
  output stream_dma_pkg::data_t     fifo_in_bits,
  output logic                      fifo_in_vld,
  input  logic                      fifo_in_rdy,
  output logic                      block_done
);

  typedef enum logic {
    fetch_idle,
    fetch_req
  } fetch_state_e;

  fetch_state_e                     state;
  logic [stream_dma_pkg::cnt_w-1:0] pending_cnt;
  stream_dma_pkg::addr_t            fetch_addr;
  logic                             b_fire;
  logic                             ar_fire;

  // host write response completes one block in memory A
  assign b_fire     = ddra_b_valid & host_b_ready;
  assign ar_fire    = ddra_ar_valid & ddra_ar_ready;
  assign block_done = b_fire;

  // --------------------
  // pending block count
  // --------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      pending_cnt <= '0;
    end else begin
      case ({b_fire, ar_fire})
        2'b10:   pending_cnt <= pending_cnt + 1'b1;
        2'b01:   pending_cnt <= pending_cnt - 1'b1;
        default: pending_cnt <= pending_cnt;
      endcase
    end
  end

  // --------------------
  // read request FSM
  // --------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state      <= fetch_idle;
      fetch_addr <= '0;
    end else begin
      case (state)
        fetch_idle: begin
          if (pending_cnt != '0) begin
            state <= fetch_req;
          end
        end
        fetch_req: begin
          if (ar_fire) begin
            state      <= fetch_idle;
            fetch_addr <= fetch_addr + stream_dma_pkg::block_bytes;
          end
        end
        default: state <= fetch_idle;
      endcase
    end
  end

  assign ddra_ar_valid = (state == fetch_req);
  assign ddra_ar.addr  = fetch_addr;
  assign ddra_ar.len   = stream_dma_pkg::burst_len;

  // read beats go straight to the kernel, back-pressure stalls memory A
  assign fifo_in_bits = ddra_r.data;
  assign fifo_in_vld  = ddra_r_valid;
  assign ddra_r_ready = fifo_in_rdy;

  // a block is only fetched after its write response was seen
  assert property (@(posedge aclk) disable iff (!aresetn)
    ar_fire |-> (pending_cnt != '0));

endmodule

//--- verilog/block_store.sv
// --------------------
// result store
// writes kernel output to memory C, one block burst per host block,
// and reports each finished burst
// --------------------

`timescale 1ns/1ns

module block_store (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      block_done,
  output stream_dma_pkg::addr_req_t ddrc_aw,
  output logic                      ddrc_aw_valid,
  input  logic                      ddrc_aw_ready,
  output stream_dma_pkg::wbeat_t    ddrc_w,
  output logic                      ddrc_w_valid,
  input  logic                      ddrc_w_ready,
  input  logic                      ddrc_b_valid,
  output logic                      ddrc_b_ready,
  input  stream_dma_pkg::data_t     fifo_out_bits,
  input  logic                      fifo_out_vld,
  output logic                      fifo_out_rdy,
  output logic                      stored
);

  logic [stream_dma_pkg::cnt_w-1:0]  wr_cnt;
  logic [stream_dma_pkg::beat_w-1:0] beat_cnt;
  stream_dma_pkg::addr_t             store_addr;
  logic                              aw_vld;
  logic                              aw_issue;
  logic                              aw_fire;
  logic                              w_fire;
  logic                              w_last;

  // new burst only when none is open
  assign aw_issue = (wr_cnt != '0) & ~aw_vld;
  assign aw_fire  = aw_vld & ddrc_aw_ready;
  assign w_fire   = ddrc_w_valid & ddrc_w_ready;
  assign w_last   = (beat_cnt == stream_dma_pkg::last_beat);

  // --------------------
  // write request side
  // --------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_cnt <= '0;
    end else begin
      case ({block_done, aw_issue})
        2'b10:   wr_cnt <= wr_cnt + 1'b1;
        2'b01:   wr_cnt <= wr_cnt - 1'b1;
        default: wr_cnt <= wr_cnt;
      endcase
    end
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      aw_vld     <= 1'b0;
      store_addr <= '0;
    end else begin
      if (aw_issue) begin
        aw_vld <= 1'b1;
      end else if (aw_fire) begin
        aw_vld     <= 1'b0;
        store_addr <= store_addr + stream_dma_pkg::block_bytes;
      end
    end
  end

  assign ddrc_aw_valid = aw_vld;
  assign ddrc_aw.addr  = store_addr;
  assign ddrc_aw.len   = stream_dma_pkg::burst_len;

  // --------------------
  // write data side
  // --------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      beat_cnt <= '0;
    end else if (w_fire) begin
      if (w_last) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  assign ddrc_w.data  = fifo_out_bits;
  assign ddrc_w.last  = w_last;
  assign ddrc_w_valid = fifo_out_vld;
  assign fifo_out_rdy = ddrc_w_ready;

  // responses are always taken, each one is a stored block
  assign ddrc_b_ready = 1'b1;
  assign stored       = ddrc_b_valid;

  // counter wraps exactly after the beat marked last
  assert property (@(posedge aclk) disable iff (!aresetn)
    w_fire |=> ((beat_cnt == '0) == $past(ddrc_w.last)));

endmodule

//--- verilog/host_read_gate.sv
// --------------------
// host read gate
// admits host read bursts on memory C only while stored result blocks
// are still unread
// --------------------

`timescale 1ns/1ns

module host_read_gate (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      stored,
  input  stream_dma_pkg::addr_req_t host_ar,
  input  logic                      host_ar_valid,
  output logic                      host_ar_ready,
  output stream_dma_pkg::addr_req_t ddrc_ar,
  output logic                      ddrc_ar_valid,
  input  logic                      ddrc_ar_ready
);

  logic [stream_dma_pkg::cnt_w-1:0] credit_cnt;
  logic [stream_dma_pkg::cnt_w-1:0] credit_nxt;
  logic                             avail;
  logic                             ar_fire;

  assign ar_fire = host_ar_valid & host_ar_ready;

  always_comb begin
    case ({stored, ar_fire})
      2'b10:   credit_nxt = credit_cnt + 1'b1;
      2'b01:   credit_nxt = credit_cnt - 1'b1;
      default: credit_nxt = credit_cnt;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      credit_cnt <= '0;
    end else begin
      credit_cnt <= credit_nxt;
    end
  end

  // rises a cycle after the credit arrives, drops together with the last credit
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      avail <= 1'b0;
    end else begin
      avail <= (credit_cnt != '0) & (credit_nxt != '0);
    end
  end

  assign ddrc_ar       = host_ar;
  assign ddrc_ar_valid = host_ar_valid & avail;
  assign host_ar_ready = ddrc_ar_ready & avail;

  // host never reads a block that has not been written back
  assert property (@(posedge aclk) disable iff (!aresetn)
    ar_fire |-> (credit_cnt != '0));

endmodule

//--- verilog/stream_dma_pkg.sv
// --------------------
// stream dma shared definitions
// beat and block geometry, channel payload structs, response codes
// --------------------

package stream_dma_pkg;

  // --------------------
  // geometry
  // --------------------
  localparam int data_w          = 64;
  localparam int addr_w          = 16;
  localparam int len_w           = 8;
  localparam int cnt_w           = 8;
  localparam int beats_per_block = 16;
  localparam int beat_w          = $clog2(beats_per_block);

  // --------------------
  // payload types
  // --------------------
  typedef logic [data_w-1:0] data_t;
  typedef logic [addr_w-1:0] addr_t;

  // AW / AR request
  typedef struct packed {
    addr_t            addr;
    logic [len_w-1:0] len;
  } addr_req_t;

  typedef struct packed {
    data_t data;
    logic  last;
  } wbeat_t;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    exokay = 2'b01,
    slverr = 2'b10,
    decerr = 2'b11
  } resp_e;

  typedef struct packed {
    data_t data;
    logic  last;
    resp_e resp;
  } rbeat_t;

  // --------------------
  // derived constants
  // --------------------
  // address stride between blocks, 128 bytes
  localparam addr_t block_bytes = addr_t'(beats_per_block * data_w / 8);

  // len field of a full block burst
  localparam logic [len_w-1:0] burst_len = len_w'(beats_per_block - 1);

  // beat index of the final beat in a block
  localparam logic [beat_w-1:0] last_beat = beat_w'(beats_per_block - 1);

endpackage

//--- verilog/stream_dma_top.sv
// --------------------
// stream dma top
// host writes to memory A, block fetch to the kernel, result store to
// memory C and gated host reads of memory C
// --------------------

`timescale 1ns/1ns

module stream_dma_top (
  input  logic                      aclk,
  input  logic                      aresetn,

  // host side
  input  stream_dma_pkg::addr_req_t host_aw,
  input  logic                      host_aw_valid,
  output logic                      host_aw_ready,
  input  stream_dma_pkg::wbeat_t    host_w,
  input  logic                      host_w_valid,
  output logic                      host_w_ready,
  output stream_dma_pkg::resp_e     host_b_resp,
  output logic                      host_b_valid,
  input  logic                      host_b_ready,
  input  stream_dma_pkg::addr_req_t host_ar,
  input  logic                      host_ar_valid,
  output logic                      host_ar_ready,
  output stream_dma_pkg::rbeat_t    host_r,
  output logic                      host_r_valid,
  input  logic                      host_r_ready,

  // memory A
  output stream_dma_pkg::addr_req_t ddra_aw,
  output logic                      ddra_aw_valid,
  input  logic                      ddra_aw_ready,
  output stream_dma_pkg::wbeat_t    ddra_w,
  output logic                      ddra_w_valid,
  input  logic                      ddra_w_ready,
  input  stream_dma_pkg::resp_e     ddra_b_resp,
  input  logic                      ddra_b_valid,
  output logic                      ddra_b_ready,
  output stream_dma_pkg::addr_req_t ddra_ar,
  output logic                      ddra_ar_valid,
  input  logic                      ddra_ar_ready,
  input  stream_dma_pkg::rbeat_t    ddra_r,
  input  logic                      ddra_r_valid,
  output logic                      ddra_r_ready,

  // memory C
  output stream_dma_pkg::addr_req_t ddrc_aw,
  output logic                      ddrc_aw_valid,
  input  logic                      ddrc_aw_ready,
  output stream_dma_pkg::wbeat_t    ddrc_w,
  output logic                      ddrc_w_valid,
  input  logic                      ddrc_w_ready,
  input  stream_dma_pkg::resp_e     ddrc_b_resp,
  input  logic                      ddrc_b_valid,
  output logic                      ddrc_b_ready,
  output stream_dma_pkg::addr_req_t ddrc_ar,
  output logic                      ddrc_ar_valid,
  input  logic                      ddrc_ar_ready,
  input  stream_dma_pkg::rbeat_t    ddrc_r,
  input  logic                      ddrc_r_valid,
  output logic                      ddrc_r_ready,

  // kernel streams
  output stream_dma_pkg::data_t     fifo_in_bits,
  output logic                      fifo_in_vld,
  input  logic                      fifo_in_rdy,
  input  stream_dma_pkg::data_t     fifo_out_bits,
  input  logic                      fifo_out_vld,
  output logic                      fifo_out_rdy
);

  logic block_done;
  logic stored;

  // --------------------
  // host write pass-through
  // --------------------
  assign ddra_aw       = host_aw;
  assign ddra_aw_valid = host_aw_valid;
  assign host_aw_ready = ddra_aw_ready;
  assign ddra_w        = host_w;
  assign ddra_w_valid  = host_w_valid;
  assign host_w_ready  = ddra_w_ready;
  assign host_b_resp   = ddra_b_resp;
  assign host_b_valid  = ddra_b_valid;
  assign ddra_b_ready  = host_b_ready;

  // host read data straight from memory C
  assign host_r       = ddrc_r;
  assign host_r_valid = ddrc_r_valid;
  assign ddrc_r_ready = host_r_ready;

  block_fetch i_block_fetch (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .ddra_b_valid  (ddra_b_valid),
    .host_b_ready  (host_b_ready),
    .ddra_ar       (ddra_ar),
    .ddra_ar_valid (ddra_ar_valid),
    .ddra_ar_ready (ddra_ar_ready),
    .ddra_r        (ddra_r),
    .ddra_r_valid  (ddra_r_valid),
    .ddra_r_ready  (ddra_r_ready),
    .fifo_in_bits  (fifo_in_bits),
    .fifo_in_vld   (fifo_in_vld),
    .fifo_in_rdy   (fifo_in_rdy),
    .block_done    (block_done)
  );

  block_store i_block_store (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .block_done    (block_done),
    .ddrc_aw       (ddrc_aw),
    .ddrc_aw_valid (ddrc_aw_valid),
    .ddrc_aw_ready (ddrc_aw_ready),
    .ddrc_w        (ddrc_w),
    .ddrc_w_valid  (ddrc_w_valid),
    .ddrc_w_ready  (ddrc_w_ready),
    .ddrc_b_valid  (ddrc_b_valid),
    .ddrc_b_ready  (ddrc_b_ready),
    .fifo_out_bits (fifo_out_bits),
    .fifo_out_vld  (fifo_out_vld),
    .fifo_out_rdy  (fifo_out_rdy),
    .stored        (stored)
  );

  host_read_gate i_host_read_gate (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .stored        (stored),
    .host_ar       (host_ar),
    .host_ar_valid (host_ar_valid),
    .host_ar_ready (host_ar_ready),
    .ddrc_ar       (ddrc_ar),
    .ddrc_ar_valid (ddrc_ar_valid),
    .ddrc_ar_ready (ddrc_ar_ready)
  );

endmodule
